/* include/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry
// 256 bytes total, two ways of eight sets each
`define CACHE_SETS 8

// 32-bit words per line, 16-byte lines
`define CACHE_WORDS 4

// backing memory
// cycles from first sight of mem_read/mem_write to mem_ready
`define MEM_LATENCY 3

`endif

/* sim.f */
+incdir+include
verilog/cache_pkg.sv
verilog/cache_way_if.sv
verilog/cache_bank.sv
verilog/lru_table.sv
verilog/cache_ctrl.sv
verilog/data_cache.sv
verification/tb_mem_model.sv
verification/tb_data_cache.sv

/* verification/tb_data_cache.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_data_cache;
  import cache_pkg::*;

  localparam int NUM_DIRECTED = 14;
  localparam int NUM_RANDOM = 40;
  localparam int MEM_WORDS = 1024;
  // directed ops, the ignored-request probe, random ops and their read-back
  localparam int OP_COUNT = NUM_DIRECTED + 1 + 2 * NUM_RANDOM;
  localparam int CYCLE_LIMIT = 16 + OP_COUNT * (2 * `MEM_LATENCY + 10) + 100;

  typedef struct packed {
    logic we;
    addr_t addr;
    word_t wdata;
    word_t rdata;
  } op_t;

  // write flag, address, write data, expected read data
  op_t directed_ops [NUM_DIRECTED] = '{
    '{1'b0, 32'h0000_0100, 32'h0, 32'hC0DE_0100},
    '{1'b0, 32'h0000_0104, 32'h0, 32'hC0DE_0104},
    '{1'b1, 32'h0000_0108, 32'h1111_2222, 32'h0},
    '{1'b0, 32'h0000_0108, 32'h0, 32'h1111_2222},
    '{1'b0, 32'h0000_010C, 32'h0, 32'hC0DE_010C},
    // set 2, three tags, first two dirty
    '{1'b1, 32'h0000_0020, 32'hAAAA_0001, 32'h0},
    '{1'b1, 32'h0000_00A4, 32'hBBBB_0002, 32'h0},
    '{1'b0, 32'h0000_0128, 32'h0, 32'hC0DE_0128},
    '{1'b0, 32'h0000_0020, 32'h0, 32'hAAAA_0001},
    '{1'b0, 32'h0000_00A4, 32'h0, 32'hBBBB_0002},
    // set 5, read only, clean evictions
    '{1'b0, 32'h0000_0050, 32'h0, 32'hC0DE_0050},
    '{1'b0, 32'h0000_00D0, 32'h0, 32'hC0DE_00D0},
    '{1'b0, 32'h0000_0154, 32'h0, 32'hC0DE_0154},
    '{1'b0, 32'h0000_0050, 32'h0, 32'hC0DE_0050}
  };

  logic clk;
  logic reset;
  logic cpu_req;
  logic cpu_we;
  addr_t cpu_addr;
  word_t cpu_wdata;
  word_t cpu_rdata;
  logic cpu_busy;
  logic cpu_done;
  logic mem_read;
  logic mem_write;
  addr_t mem_addr;
  line_t mem_wdata;
  line_t mem_rdata;
  logic mem_ready;
  int fault_count;

  int errors = 0;
  int cycles = 0;
  logic [31:0] rng_state = 32'd92298;

  // expected memory contents, word addressed
  word_t shadow [MEM_WORDS];
  // expected tag state per set and way, victim way per set
  tag_t pred_tag [`CACHE_SETS][2];
  logic pred_valid [`CACHE_SETS][2];
  logic pred_dirty [`CACHE_SETS][2];
  logic pred_victim [`CACHE_SETS];
  addr_t touched [$];

  data_cache i_data_cache (
    .clk(clk), .reset(reset),
    .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .cpu_rdata(cpu_rdata), .cpu_busy(cpu_busy), .cpu_done(cpu_done),
    .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
  );

  tb_mem_model i_mem_model (
    .clk(clk), .reset(reset),
    .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready),
    .fault_count(fault_count)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t %s actual=%h expected=%h", $time, name, actual, expected);
    end
  endtask

  // hit, LRU victim and write-back decision from the cache rules
  task automatic predict_access(input addr_t addr, input logic we, output logic hit,
                                output logic wb, output addr_t wb_addr);
    set_idx_t s;
    tag_t t;
    int w;
    s = addr[6:4];
    t = addr[31:7];
    hit = 1'b0;
    wb = 1'b0;
    wb_addr = '0;
    w = 0;
    for (int i = 0; i < 2; i++) begin
      if (pred_valid[s][i] && pred_tag[s][i] == t) begin
        hit = 1'b1;
        w = i;
      end
    end
    if (!hit) begin
      w = int'(pred_victim[s]);
      wb = pred_valid[s][w] && pred_dirty[s][w];
      wb_addr = {pred_tag[s][w], s, 4'b0000};
      pred_tag[s][w] = t;
      pred_valid[s][w] = 1'b1;
      pred_dirty[s][w] = 1'b0;
    end
    pred_victim[s] = (w == 0);
    if (we) pred_dirty[s][w] = 1'b1;
  endtask

  // one processor access; stray adds a request while the cache is busy
  task automatic cache_access(input logic we, input addr_t addr, input word_t wdata,
                              input word_t exp, input logic stray);
    logic hit;
    logic wb;
    addr_t wb_addr;
    addr_t wb_seen;
    int lat;
    logic seen_read;
    logic seen_write;
    logic done_seen;
    predict_access(addr, we, hit, wb, wb_addr);
    lat = 0;
    seen_read = 1'b0;
    seen_write = 1'b0;
    done_seen = 1'b0;
    wb_seen = '0;
    @(negedge clk);
    cpu_we = we;
    cpu_addr = addr;
    cpu_wdata = wdata;
    cpu_req = 1'b1;
    while (!done_seen) begin
      @(negedge clk);
      lat++;
      if (mem_read) seen_read = 1'b1;
      if (mem_write) begin
        seen_write = 1'b1;
        wb_seen = mem_addr;
      end
      done_seen = cpu_done;
      if (lat == 1) begin
        compare("cpu_busy", cpu_busy, 1);
        cpu_req = stray;
        cpu_we = 1'b1;
        cpu_addr = addr ^ 32'h0000_0040;
        cpu_wdata = 32'hDEAD_BEEF;
      end
      if (lat == 2) cpu_req = 1'b0;
    end
    if (hit) begin
      compare("done latency", lat, 2);
      compare("mem_read", seen_read, 0);
      compare("mem_write", seen_write, 0);
    end else begin
      compare("mem_read", seen_read, 1);
      compare("mem_write", seen_write, wb);
      if (wb) compare("mem_addr", wb_seen, wb_addr);
    end
    if (we) begin
      shadow[addr[11:2]] = wdata;
    end else begin
      compare("cpu_rdata", cpu_rdata, exp);
    end
  endtask

  initial begin
    addr_t r_addr;
    logic r_we;
    int extra;
    cpu_req = 1'b0;
    cpu_we = 1'b0;
    cpu_addr = '0;
    cpu_wdata = '0;
    reset = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = word_t'(i * 4) ^ 32'hC0DE0000;
    end
    for (int s = 0; s < `CACHE_SETS; s++) begin
      pred_victim[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        pred_tag[s][w] = '0;
        pred_valid[s][w] = 1'b0;
        pred_dirty[s][w] = 1'b0;
      end
    end

    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    compare("cpu_busy", cpu_busy, 0);
    compare("cpu_done", cpu_done, 0);
    compare("mem_read", mem_read, 0);
    compare("mem_write", mem_write, 0);

    foreach (directed_ops[i]) begin
      cache_access(directed_ops[i].we, directed_ops[i].addr, directed_ops[i].wdata,
                   directed_ops[i].rdata, 1'b0);
    end

    // a request raised during a busy access must not produce a second done
    cache_access(1'b0, 32'h0000_0154, '0, 32'hC0DE_0154, 1'b1);
    extra = 0;
    repeat (4) begin
      @(negedge clk);
      if (cpu_done) extra++;
    end
    compare("extra cpu_done", extra, 0);

    // four tags over all sets keep the ways in conflict
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rng_state = xorshift32(rng_state);
      r_addr = {25'(1 + rng_state[1:0]), rng_state[4:2], rng_state[6:5], 2'b00};
      r_we = rng_state[7];
      rng_state = xorshift32(rng_state);
      cache_access(r_we, r_addr, rng_state, shadow[r_addr[11:2]], 1'b0);
      touched.push_back(r_addr);
    end

    foreach (touched[i]) begin
      cache_access(1'b0, touched[i], '0, shadow[touched[i][11:2]], 1'b0);
    end

    $display("summary: %0d check errors, %0d memory model faults", errors, fault_count);
    if (errors == 0 && fault_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verification/tb_mem_model.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_mem_model (
  input logic clk,
  input logic reset,
  input logic mem_read,
  input logic mem_write,
  input cache_pkg::addr_t mem_addr,
  input cache_pkg::line_t mem_wdata,
  output cache_pkg::line_t mem_rdata,
  output logic mem_ready,
  output int fault_count
);
  import cache_pkg::*;

  localparam int MEM_WORDS = 1024;

  word_t mem_words [MEM_WORDS];
  int wait_cnt;
  int base;
  line_t rd_line;

  initial begin
    // every word starts as its byte address xor a fixed marker
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_words[i] = word_t'(i * 4) ^ 32'hC0DE0000;
    end
    mem_rdata = '0;
    mem_ready = 1'b0;
    fault_count = 0;
    wait_cnt = 0;
  end

  // one line per transfer, answered a fixed number of cycles after first sight
  always @(negedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      wait_cnt <= 0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;
      // a refill straight after a write-back is first seen here
      wait_cnt <= (mem_read || mem_write) ? 1 : 0;
    end else if (mem_read || mem_write) begin
      if (mem_read && mem_write) begin
        fault_count++;
        $display("memory model: mem_read and mem_write both high at %0t", $time);
      end
      if (wait_cnt == `MEM_LATENCY - 1) begin
        if (mem_addr[3:0] != 4'h0 || mem_addr[31:12] != '0) begin
          fault_count++;
          $display("memory model: address %h is not line-aligned or out of range at %0t",
                   mem_addr, $time);
        end else begin
          base = int'(mem_addr[11:2]);
          for (int w = 0; w < `CACHE_WORDS; w++) begin
            if (mem_write) begin
              mem_words[base + w] = mem_wdata[w*32 +: 32];
            end
            rd_line[w*32 +: 32] = mem_words[base + w];
          end
          if (mem_read) begin
            mem_rdata <= rd_line;
          end
        end
        mem_ready <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end else begin
      wait_cnt <= 0;
    end
  end

endmodule

/* verilog/cache_bank.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_bank (
  input logic clk,
  input logic reset,
  cache_way_if.bank way
);
  import cache_pkg::*;

  // per-set storage for this way
  tag_t tag_mem [`CACHE_SETS];
  line_t data_mem [`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid_bits;
  logic [`CACHE_SETS-1:0] dirty_bits;

  // indexed line with the store word merged in
  line_t wr_line;

  // read side of the indexed set
  assign way.rd_tag = tag_mem[way.index];
  assign way.rd_line = data_mem[way.index];
  assign way.valid = valid_bits[way.index];
  assign way.dirty = dirty_bits[way.index];

  // tag match only counts on a valid entry
  assign way.hit = way.valid && (way.rd_tag == way.tag);

  // word select and word merge share the offset decode
  always_comb begin
    way.rd_word = '0;
    wr_line = way.rd_line;
    for (int w = 0; w < `CACHE_WORDS; w++) begin
      if (way.offset == word_off_t'(w)) begin
        way.rd_word = way.rd_line[w*32 +: 32];
        wr_line[w*32 +: 32] = way.wr_word;
      end
    end
  end

  // status bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (way.fill_en) begin
      // freshly refilled line matches memory
      valid_bits[way.index] <= 1'b1;
      dirty_bits[way.index] <= 1'b0;
    end else if (way.wr_en) begin
      dirty_bits[way.index] <= 1'b1;
    end
  end

  // tag and line storage
  always_ff @(posedge clk) begin
    if (way.fill_en) begin
      tag_mem[way.index] <= way.fill_tag;
      data_mem[way.index] <= way.fill_line;
    end else if (way.wr_en) begin
      data_mem[way.index] <= wr_line;
    end
  end

endmodule

/* verilog/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
  input logic clk,
  input logic reset,
  cache_way_if.ctrl way0,
  cache_way_if.ctrl way1,
  output cache_pkg::set_idx_t lru_index,
  output logic touch,
  output logic touch_way,
  input logic victim_way,
  input logic cpu_req,
  input logic cpu_we,
  input cache_pkg::addr_t cpu_addr,
  input cache_pkg::word_t cpu_wdata,
  output cache_pkg::word_t cpu_rdata,
  output logic cpu_busy,
  output logic cpu_done,
  output logic mem_read,
  output logic mem_write,
  output cache_pkg::addr_t mem_addr,
  output cache_pkg::line_t mem_wdata,
  input cache_pkg::line_t mem_rdata,
  input logic mem_ready
);
  import cache_pkg::*;

  cache_state_t state;

  // captured request
  logic req_we;
  addr_t req_addr;
  word_t req_wdata;
  tag_t req_tag;
  set_idx_t req_index;
  word_off_t req_offset;
  addr_t refill_addr;

  // victim way, held from COMPARE through the refill
  logic victim;

  logic hit_any;
  logic vic_dirty;
  tag_t vic_tag;
  line_t vic_line;
  addr_t vic_addr;

  assign req_tag = req_addr[31:7];
  assign req_index = req_addr[6:4];
  assign req_offset = req_addr[3:2];
  assign refill_addr = {req_tag, req_index, 4'b0000};

  assign hit_any = way0.hit || way1.hit;

  // fields of the way the LRU table proposes for eviction
  assign vic_dirty = victim_way ? (way1.valid && way1.dirty) : (way0.valid && way0.dirty);
  assign vic_tag = victim_way ? way1.rd_tag : way0.rd_tag;
  assign vic_line = victim_way ? way1.rd_line : way0.rd_line;
  assign vic_addr = {vic_tag, req_index, 4'b0000};

  // both ways look up the same set
  assign way0.index = req_index;
  assign way0.tag = req_tag;
  assign way0.offset = req_offset;
  assign way0.wr_word = req_wdata;
  assign way0.fill_line = mem_rdata;
  assign way0.fill_tag = req_tag;
  assign way1.index = req_index;
  assign way1.tag = req_tag;
  assign way1.offset = req_offset;
  assign way1.wr_word = req_wdata;
  assign way1.fill_line = mem_rdata;
  assign way1.fill_tag = req_tag;

  // store on a write hit
  assign way0.wr_en = (state == COMPARE) && req_we && way0.hit;
  assign way1.wr_en = (state == COMPARE) && req_we && way1.hit;

  // install the refilled line into the victim way as it arrives
  assign way0.fill_en = (state == REFILL) && mem_ready && !victim;
  assign way1.fill_en = (state == REFILL) && mem_ready && victim;

  // recency update on every hit, refill hits included
  assign lru_index = req_index;
  assign touch = (state == COMPARE) && hit_any;
  assign touch_way = way1.hit;

  assign cpu_busy = (state != IDLE);
  assign cpu_done = (state == RESPOND);

  // state and memory request levels
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      mem_read <= 1'b0;
      mem_write <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (cpu_req) state <= COMPARE;
        end
        COMPARE: begin
          if (hit_any) begin
            state <= RESPOND;
          end else if (vic_dirty) begin
            state <= WRITEBACK;
            mem_write <= 1'b1;
          end else begin
            state <= REFILL;
            mem_read <= 1'b1;
          end
        end
        WRITEBACK: begin
          // old line is out, fetch the new one
          if (mem_ready) begin
            mem_write <= 1'b0;
            mem_read <= 1'b1;
            state <= REFILL;
          end
        end
        REFILL: begin
          // retry the lookup, which now hits
          if (mem_ready) begin
            mem_read <= 1'b0;
            state <= COMPARE;
          end
        end
        RESPOND: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // request capture, read data and memory payload
  always_ff @(posedge clk) begin
    if (state == IDLE && cpu_req) begin
      req_we <= cpu_we;
      req_addr <= cpu_addr;
      req_wdata <= cpu_wdata;
    end
    if (state == COMPARE) begin
      if (!req_we && hit_any) cpu_rdata <= way1.hit ? way1.rd_word : way0.rd_word;
      if (!hit_any) begin
        victim <= victim_way;
        mem_addr <= vic_dirty ? vic_addr : refill_addr;
        mem_wdata <= vic_line;
      end
    end
    if (state == WRITEBACK && mem_ready) mem_addr <= refill_addr;
  end

endmodule

/* verilog/cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

  // byte address split into tag | set index | word offset | byte offset
  typedef logic [31:0] addr_t;
  typedef logic [24:0] tag_t;
  typedef logic [2:0] set_idx_t;
  typedef logic [1:0] word_off_t;

  // data widths
  typedef logic [31:0] word_t;
  // word 0 sits in the low 32 bits
  typedef logic [`CACHE_WORDS*32-1:0] line_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRITEBACK,
    REFILL,
    RESPOND
  } cache_state_t;

endpackage

/* verilog/cache_way_if.sv */
`timescale 1ns/1ps

interface cache_way_if;
  import cache_pkg::*;

  // lookup, from the controller
  set_idx_t index;
  tag_t tag;
  word_off_t offset;

  // single word store, sets dirty
  logic wr_en;
  word_t wr_word;

  // line install after refill, clean and valid
  logic fill_en;
  line_t fill_line;
  tag_t fill_tag;

  // lookup result, combinational in the bank
  logic hit;
  logic valid;
  logic dirty;
  tag_t rd_tag;
  line_t rd_line;
  word_t rd_word;

  modport ctrl (
    output index, tag, offset, wr_en, wr_word, fill_en, fill_line, fill_tag,
    input hit, valid, dirty, rd_tag, rd_line, rd_word
  );

  modport bank (
    input index, tag, offset, wr_en, wr_word, fill_en, fill_line, fill_tag,
    output hit, valid, dirty, rd_tag, rd_line, rd_word
  );

endinterface

/* verilog/data_cache.sv */
`timescale 1ns/1ps

module data_cache (
  input logic clk,
  input logic reset,
  // processor side
  input logic cpu_req,
  input logic cpu_we,
  input cache_pkg::addr_t cpu_addr,
  input cache_pkg::word_t cpu_wdata,
  output cache_pkg::word_t cpu_rdata,
  output logic cpu_busy,
  output logic cpu_done,
  // memory side, one line per transfer
  output logic mem_read,
  output logic mem_write,
  output cache_pkg::addr_t mem_addr,
  output cache_pkg::line_t mem_wdata,
  input cache_pkg::line_t mem_rdata,
  input logic mem_ready
);
  import cache_pkg::*;

  // lru table hookup
  set_idx_t lru_index;
  logic touch;
  logic touch_way;
  logic victim_way;

  // one bundle per way
  cache_way_if way0_if ();
  cache_way_if way1_if ();

  cache_ctrl i_cache_ctrl (
    .clk(clk),
    .reset(reset),
    .way0(way0_if.ctrl),
    .way1(way1_if.ctrl),
    .lru_index(lru_index),
    .touch(touch),
    .touch_way(touch_way),
    .victim_way(victim_way),
    .cpu_req(cpu_req),
    .cpu_we(cpu_we),
    .cpu_addr(cpu_addr),
    .cpu_wdata(cpu_wdata),
    .cpu_rdata(cpu_rdata),
    .cpu_busy(cpu_busy),
    .cpu_done(cpu_done),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready)
  );

  cache_bank i_bank0 (
    .clk(clk),
    .reset(reset),
    .way(way0_if.bank)
  );

  cache_bank i_bank1 (
    .clk(clk),
    .reset(reset),
    .way(way1_if.bank)
  );

  lru_table i_lru_table (
    .clk(clk),
    .reset(reset),
    .lru_index(lru_index),
    .touch(touch),
    .touch_way(touch_way),
    .victim_way(victim_way)
  );

endmodule

/* verilog/lru_table.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module lru_table (
  input logic clk,
  input logic reset,
  input cache_pkg::set_idx_t lru_index,
  input logic touch,
  input logic touch_way,
  output logic victim_way
);

  // one bit per set, names the least recently used way
  logic [`CACHE_SETS-1:0] lru_bits;

  // victim lookup is combinational
  assign victim_way = lru_bits[lru_index];

  always_ff @(posedge clk) begin
    if (reset) begin
      // way 0 is the first victim in every set
      lru_bits <= '0;
    end else if (touch) begin
      // the way not just used becomes the next victim
      lru_bits[lru_index] <= ~touch_way;
    end
  end

endmodule
